//--- hw/cpu_params.svh
`ifndef CPU_PARAMS_SVH
`define CPU_PARAMS_SVH

// datapath widths
`define DATA_W      32
`define ADDR_W      32
`define INST_W      32
`define REG_ADDR_W  5
`define SHAMT_W     5
`define ALU_OP_W    4

// instruction field positions
`define OPCODE_HI   31
`define OPCODE_LO   26
`define RS_HI       25
`define RS_LO       21
`define RT_HI       20
`define RT_LO       16
`define RD_HI       15
`define RD_LO       11
`define SHAMT_HI    10
`define SHAMT_LO    6
`define FUNCT_HI    5
`define FUNCT_LO    0
`define IMM_HI      15
`define IMM_LO      0

// opcodes
`define OP_SPECIAL  6'b000000
`define OP_ORI      6'b001101
`define OP_ANDI     6'b001100
`define OP_XORI     6'b001110
`define OP_LUI      6'b001111
`define OP_ADDIU    6'b001001

// funct codes under SPECIAL
`define FUNCT_OR    6'b100101
`define FUNCT_AND   6'b100100
`define FUNCT_XOR   6'b100110
`define FUNCT_NOR   6'b100111
`define FUNCT_ADDU  6'b100001
`define FUNCT_SUBU  6'b100011
`define FUNCT_SLT   6'b101010
`define FUNCT_SLL   6'b000000
`define FUNCT_SRL   6'b000010

// first fetch address and increment
`define RESET_PC    32'hbfc0_0000
`define PC_STEP     32'd4

`endif

//--- hw/cpu_pkg.sv
`include "cpu_params.svh"

package cpu_pkg;

    // operation handed from decode to execute
    typedef enum logic [`ALU_OP_W-1:0] {
        ALU_NOP  = 4'd0,
        ALU_OR   = 4'd1,
        ALU_AND  = 4'd2,
        ALU_XOR  = 4'd3,
        ALU_NOR  = 4'd4,
        ALU_ADDU = 4'd5,
        ALU_SUBU = 4'd6,
        ALU_SLT  = 4'd7,
        ALU_SLL  = 4'd8,
        ALU_SRL  = 4'd9
    } alu_op_e;

endpackage

//--- hw/inst_fetch.sv
`timescale 1ns/100ps

`include "cpu_params.svh"

module inst_fetch (
    input  logic               clk,
    input  logic               rst,
    input  logic               inst_ack,
    input  logic [`INST_W-1:0] inst_data,
    output logic               inst_req,
    output logic [`ADDR_W-1:0] inst_addr,
    output logic               fetch_valid,
    output logic [`ADDR_W-1:0] fetch_addr,
    output logic [`INST_W-1:0] fetch_inst
);

    typedef enum logic {
        S_RELEASE,
        S_REQ
    } fetch_state_e;

    fetch_state_e       state;
    logic [`ADDR_W-1:0] pc;
    logic               capture;

    // word delivered while request is up
    assign capture   = (state == S_REQ) && inst_ack;
    assign inst_req  = (state == S_REQ);
    assign inst_addr = pc;

    always_ff @(posedge clk) begin
        if (!rst) begin
            state       <= S_RELEASE;
            pc          <= `RESET_PC;
            fetch_valid <= 1'b0;
        end else begin
            fetch_valid <= capture;
            case (state)
                // wait for source to drop ack before a new request
                S_RELEASE: begin
                    if (!inst_ack) begin
                        state <= S_REQ;
                    end
                end
                S_REQ: begin
                    if (capture) begin
                        state <= S_RELEASE;
                        pc    <= pc + `PC_STEP;
                    end
                end
                default: state <= S_RELEASE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (capture) begin
            fetch_addr <= pc;
            fetch_inst <= inst_data;
        end
    end

endmodule

//--- hw/inst_decode.sv
`timescale 1ns/100ps

`include "cpu_params.svh"

module inst_decode (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   fetch_valid,
    input  logic [`INST_W-1:0]     fetch_inst,
    input  logic [`DATA_W-1:0]     rd_data_1,
    input  logic [`DATA_W-1:0]     rd_data_2,
    output logic                   rd_en_1,
    output logic                   rd_en_2,
    output logic [`REG_ADDR_W-1:0] rd_addr_1,
    output logic [`REG_ADDR_W-1:0] rd_addr_2,
    output logic                   ex_valid,
    output cpu_pkg::alu_op_e       ex_op,
    output logic [`SHAMT_W-1:0]    ex_shamt,
    output logic [`DATA_W-1:0]     ex_operand_1,
    output logic [`DATA_W-1:0]     ex_operand_2,
    output logic                   ex_wb_en,
    output logic [`REG_ADDR_W-1:0] ex_wb_addr
);

    logic [`OPCODE_HI-`OPCODE_LO:0] opcode;
    logic [`REG_ADDR_W-1:0]         rs;
    logic [`REG_ADDR_W-1:0]         rt;
    logic [`REG_ADDR_W-1:0]         rd;
    logic [`SHAMT_W-1:0]            shamt;
    logic [`FUNCT_HI-`FUNCT_LO:0]   funct;
    logic [`IMM_HI-`IMM_LO:0]       imm;
    logic [`DATA_W-1:0]             imm_zext;
    logic [`DATA_W-1:0]             imm_sext;
    logic [`DATA_W-1:0]             imm_hi;

    cpu_pkg::alu_op_e               dec_op;
    logic [`DATA_W-1:0]             dec_operand_1;
    logic [`DATA_W-1:0]             dec_operand_2;
    logic                           dec_wb_en;
    logic [`REG_ADDR_W-1:0]         dec_wb_addr;

    assign opcode = fetch_inst[`OPCODE_HI:`OPCODE_LO];
    assign rs     = fetch_inst[`RS_HI:`RS_LO];
    assign rt     = fetch_inst[`RT_HI:`RT_LO];
    assign rd     = fetch_inst[`RD_HI:`RD_LO];
    assign shamt  = fetch_inst[`SHAMT_HI:`SHAMT_LO];
    assign funct  = fetch_inst[`FUNCT_HI:`FUNCT_LO];
    assign imm    = fetch_inst[`IMM_HI:`IMM_LO];

    assign imm_zext = {{(`DATA_W - $bits(imm)){1'b0}}, imm};
    assign imm_sext = {{(`DATA_W - $bits(imm)){imm[$bits(imm)-1]}}, imm};
    assign imm_hi   = {imm, {(`DATA_W - $bits(imm)){1'b0}}};

    always_comb begin
        rd_en_1       = 1'b0;
        rd_en_2       = 1'b0;
        rd_addr_1     = '0;
        rd_addr_2     = '0;
        dec_op        = cpu_pkg::ALU_NOP;
        dec_operand_1 = rd_data_1;
        dec_operand_2 = rd_data_2;
        dec_wb_en     = 1'b0;
        dec_wb_addr   = rt;
        case (opcode)
            `OP_SPECIAL: begin
                rd_en_1     = 1'b1;
                rd_en_2     = 1'b1;
                rd_addr_1   = rs;
                rd_addr_2   = rt;
                dec_wb_addr = rd;
                case (funct)
                    `FUNCT_OR:   dec_op = cpu_pkg::ALU_OR;
                    `FUNCT_AND:  dec_op = cpu_pkg::ALU_AND;
                    `FUNCT_XOR:  dec_op = cpu_pkg::ALU_XOR;
                    `FUNCT_NOR:  dec_op = cpu_pkg::ALU_NOR;
                    `FUNCT_ADDU: dec_op = cpu_pkg::ALU_ADDU;
                    `FUNCT_SUBU: dec_op = cpu_pkg::ALU_SUBU;
                    `FUNCT_SLT:  dec_op = cpu_pkg::ALU_SLT;
                    `FUNCT_SLL:  dec_op = cpu_pkg::ALU_SLL;
                    `FUNCT_SRL:  dec_op = cpu_pkg::ALU_SRL;
                    default:     dec_op = cpu_pkg::ALU_NOP;
                endcase
                // unknown funct falls through as a no-op
                dec_wb_en = (dec_op != cpu_pkg::ALU_NOP);
            end
            `OP_ORI, `OP_ANDI, `OP_XORI: begin
                rd_en_1       = 1'b1;
                rd_addr_1     = rs;
                dec_operand_2 = imm_zext;
                dec_wb_en     = 1'b1;
                if (opcode == `OP_ORI) begin
                    dec_op = cpu_pkg::ALU_OR;
                end else if (opcode == `OP_ANDI) begin
                    dec_op = cpu_pkg::ALU_AND;
                end else begin
                    dec_op = cpu_pkg::ALU_XOR;
                end
            end
            `OP_ADDIU: begin
                rd_en_1       = 1'b1;
                rd_addr_1     = rs;
                dec_op        = cpu_pkg::ALU_ADDU;
                dec_operand_2 = imm_sext;
                dec_wb_en     = 1'b1;
            end
            // lui is an or of the shifted immediate with zero
            `OP_LUI: begin
                dec_op        = cpu_pkg::ALU_OR;
                dec_operand_1 = '0;
                dec_operand_2 = imm_hi;
                dec_wb_en     = 1'b1;
            end
            default: dec_op = cpu_pkg::ALU_NOP;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst) begin
            ex_valid <= 1'b0;
        end else begin
            ex_valid <= fetch_valid;
        end
    end

    always_ff @(posedge clk) begin
        ex_op        <= dec_op;
        ex_shamt     <= shamt;
        ex_operand_1 <= dec_operand_1;
        ex_operand_2 <= dec_operand_2;
        ex_wb_en     <= dec_wb_en;
        ex_wb_addr   <= dec_wb_addr;
    end

endmodule

//--- hw/reg_file.sv
`timescale 1ns/100ps

`include "cpu_params.svh"

module reg_file (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   rd_en_1,
    input  logic                   rd_en_2,
    input  logic [`REG_ADDR_W-1:0] rd_addr_1,
    input  logic [`REG_ADDR_W-1:0] rd_addr_2,
    input  logic                   wb_en,
    input  logic [`REG_ADDR_W-1:0] wb_addr,
    input  logic [`DATA_W-1:0]     wb_data,
    output logic [`DATA_W-1:0]     rd_data_1,
    output logic [`DATA_W-1:0]     rd_data_2
);

    logic [`DATA_W-1:0] regs [2**`REG_ADDR_W];

    // one read port, with zero register and write-through
    function automatic logic [`DATA_W-1:0] read_port(
        input logic                   en,
        input logic [`REG_ADDR_W-1:0] addr
    );
        logic [`DATA_W-1:0] value;
        if (!en || addr == '0) begin
            value = '0;
        end else if (wb_en && wb_addr == addr) begin
            value = wb_data;
        end else begin
            value = regs[addr];
        end
        return value;
    endfunction

    always_ff @(posedge clk) begin
        if (!rst) begin
            for (int i = 0; i < 2**`REG_ADDR_W; i++) begin
                regs[i] <= '0;
            end
        end else if (wb_en && wb_addr != '0) begin
            regs[wb_addr] <= wb_data;
        end
    end

    always_comb begin
        rd_data_1 = read_port(rd_en_1, rd_addr_1);
        rd_data_2 = read_port(rd_en_2, rd_addr_2);
    end

endmodule

//--- hw/alu_execute.sv
`timescale 1ns/100ps

`include "cpu_params.svh"

module alu_execute (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   ex_valid,
    input  cpu_pkg::alu_op_e       ex_op,
    input  logic [`SHAMT_W-1:0]    ex_shamt,
    input  logic [`DATA_W-1:0]     ex_operand_1,
    input  logic [`DATA_W-1:0]     ex_operand_2,
    input  logic                   ex_wb_en,
    input  logic [`REG_ADDR_W-1:0] ex_wb_addr,
    output logic                   wb_en,
    output logic [`REG_ADDR_W-1:0] wb_addr,
    output logic [`DATA_W-1:0]     wb_data
);

    logic [`DATA_W-1:0] result;
    logic               less;

    // signed compare for slt
    assign less = $signed(ex_operand_1) < $signed(ex_operand_2);

    always_comb begin
        case (ex_op)
            cpu_pkg::ALU_OR: begin
                result = ex_operand_1 | ex_operand_2;
            end
            cpu_pkg::ALU_AND: begin
                result = ex_operand_1 & ex_operand_2;
            end
            cpu_pkg::ALU_XOR: begin
                result = ex_operand_1 ^ ex_operand_2;
            end
            cpu_pkg::ALU_NOR: begin
                result = ~(ex_operand_1 | ex_operand_2);
            end
            cpu_pkg::ALU_ADDU: begin
                result = ex_operand_1 + ex_operand_2;
            end
            cpu_pkg::ALU_SUBU: begin
                result = ex_operand_1 - ex_operand_2;
            end
            cpu_pkg::ALU_SLT: begin
                result = {{(`DATA_W - 1){1'b0}}, less};
            end
            // shifts act on rt, which arrives as operand 2
            cpu_pkg::ALU_SLL: begin
                result = ex_operand_2 << ex_shamt;
            end
            cpu_pkg::ALU_SRL: begin
                result = ex_operand_2 >> ex_shamt;
            end
            default: begin
                result = '0;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst) begin
            wb_en <= 1'b0;
        end else begin
            wb_en <= ex_valid && ex_wb_en;
        end
    end

    always_ff @(posedge clk) begin
        wb_addr <= ex_wb_addr;
        wb_data <= result;
    end

endmodule

//--- hw/cpu_core.sv
`timescale 1ns/100ps

`include "cpu_params.svh"

module cpu_core (
    input  logic                   clk,
    input  logic                   rst,
    output logic                   inst_req,
    output logic [`ADDR_W-1:0]     inst_addr,
    input  logic                   inst_ack,
    input  logic [`INST_W-1:0]     inst_data,
    output logic                   wb_en,
    output logic [`REG_ADDR_W-1:0] wb_addr,
    output logic [`DATA_W-1:0]     wb_data
);

    logic                   fetch_valid;
    logic [`ADDR_W-1:0]     fetch_addr;
    logic [`INST_W-1:0]     fetch_inst;

    logic                   rd_en_1;
    logic                   rd_en_2;
    logic [`REG_ADDR_W-1:0] rd_addr_1;
    logic [`REG_ADDR_W-1:0] rd_addr_2;
    logic [`DATA_W-1:0]     rd_data_1;
    logic [`DATA_W-1:0]     rd_data_2;

    logic                   ex_valid;
    cpu_pkg::alu_op_e       ex_op;
    logic [`SHAMT_W-1:0]    ex_shamt;
    logic [`DATA_W-1:0]     ex_operand_1;
    logic [`DATA_W-1:0]     ex_operand_2;
    logic                   ex_wb_en;
    logic [`REG_ADDR_W-1:0] ex_wb_addr;

    inst_fetch u_fetch (
        .clk         (clk),
        .rst         (rst),
        .inst_ack    (inst_ack),
        .inst_data   (inst_data),
        .inst_req    (inst_req),
        .inst_addr   (inst_addr),
        .fetch_valid (fetch_valid),
        .fetch_addr  (fetch_addr),
        .fetch_inst  (fetch_inst)
    );

    inst_decode u_decode (
        .clk          (clk),
        .rst          (rst),
        .fetch_valid  (fetch_valid),
        .fetch_inst   (fetch_inst),
        .rd_data_1    (rd_data_1),
        .rd_data_2    (rd_data_2),
        .rd_en_1      (rd_en_1),
        .rd_en_2      (rd_en_2),
        .rd_addr_1    (rd_addr_1),
        .rd_addr_2    (rd_addr_2),
        .ex_valid     (ex_valid),
        .ex_op        (ex_op),
        .ex_shamt     (ex_shamt),
        .ex_operand_1 (ex_operand_1),
        .ex_operand_2 (ex_operand_2),
        .ex_wb_en     (ex_wb_en),
        .ex_wb_addr   (ex_wb_addr)
    );

    // writeback drives the write port and the external trace
    reg_file u_reg_file (
        .clk       (clk),
        .rst       (rst),
        .rd_en_1   (rd_en_1),
        .rd_en_2   (rd_en_2),
        .rd_addr_1 (rd_addr_1),
        .rd_addr_2 (rd_addr_2),
        .wb_en     (wb_en),
        .wb_addr   (wb_addr),
        .wb_data   (wb_data),
        .rd_data_1 (rd_data_1),
        .rd_data_2 (rd_data_2)
    );

    alu_execute u_execute (
        .clk          (clk),
        .rst          (rst),
        .ex_valid     (ex_valid),
        .ex_op        (ex_op),
        .ex_shamt     (ex_shamt),
        .ex_operand_1 (ex_operand_1),
        .ex_operand_2 (ex_operand_2),
        .ex_wb_en     (ex_wb_en),
        .ex_wb_addr   (ex_wb_addr),
        .wb_en        (wb_en),
        .wb_addr      (wb_addr),
        .wb_data      (wb_data)
    );

endmodule

//--- dv/cpu_chk.sv
`timescale 1ns/100ps

`include "cpu_params.svh"

module cpu_chk (
    input logic               clk,
    input logic               rst,
    input logic               inst_req,
    input logic               inst_ack,
    input logic [`ADDR_W-1:0] inst_addr,
    input logic               wb_en
);

    int fail_count = 0;

    // request held until the source answers
    req_held: assert property (@(posedge clk) disable iff (!rst)
        inst_req && !inst_ack |=> inst_req)
        else begin
            fail_count++;
            $error("inst_req dropped before inst_ack");
        end

    req_no_rise: assert property (@(posedge clk) disable iff (!rst)
        !inst_req && inst_ack |=> !inst_req)
        else begin
            fail_count++;
            $error("inst_req rose while inst_ack was high");
        end

    addr_step: assert property (@(posedge clk) disable iff (!rst)
        inst_req && inst_ack |=> inst_addr == $past(inst_addr) + `PC_STEP)
        else begin
            fail_count++;
            $error("inst_addr did not advance by one step after a handshake");
        end

    wb_quiet_in_reset: assert property (@(posedge clk) !rst |=> !wb_en)
        else begin
            fail_count++;
            $error("wb_en high during reset");
        end

endmodule

bind cpu_core cpu_chk u_chk (
    .clk       (clk),
    .rst       (rst),
    .inst_req  (inst_req),
    .inst_ack  (inst_ack),
    .inst_addr (inst_addr),
    .wb_en     (wb_en)
);

//--- dv/cpu_tb.sv
`timescale 1ns/100ps

`include "cpu_params.svh"

module cpu_tb;

    // about 150 instructions at up to 6 cycles each, plus reset
    localparam int MAX_CYCLES = 3000;
    // opcode 0x3f, not in the instruction set
    localparam logic [`INST_W-1:0] NOP_WORD = 32'hfc00_0000;

    logic                   clk;
    logic                   rst;
    logic                   inst_req;
    logic [`ADDR_W-1:0]     inst_addr;
    logic                   inst_ack;
    logic [`INST_W-1:0]     inst_data;
    logic                   wb_en;
    logic [`REG_ADDR_W-1:0] wb_addr;
    logic [`DATA_W-1:0]     wb_data;

    integer                 seed = 32'h55b5da77;
    int                     cycle_count;
    logic                   zero_delay;
    int unsigned            delay;
    int                     idx;
    int                     served;
    int                     prog_len;
    logic [`INST_W-1:0]     word;
    logic [`ADDR_W-1:0]     next_fetch_addr;
    logic [`INST_W-1:0]     prog_mem [2048];
    logic [`DATA_W-1:0]     model_regs [32];
    logic [`REG_ADDR_W-1:0] exp_addr_q [$];
    logic [`DATA_W-1:0]     exp_data_q [$];

    cpu_core u_dut (
        .clk       (clk),
        .rst       (rst),
        .inst_req  (inst_req),
        .inst_addr (inst_addr),
        .inst_ack  (inst_ack),
        .inst_data (inst_data),
        .wb_en     (wb_en),
        .wb_addr   (wb_addr),
        .wb_data   (wb_data)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    task automatic stop_on_error();
        $display("tests failed");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_word(input string name, input logic [`DATA_W-1:0] got,
                              input logic [`DATA_W-1:0] exp);
        if (got !== exp) begin
            $display("[ERROR] %0t %s got %h expected %h", $time, name, got, exp);
            stop_on_error();
        end
    endtask

    task automatic check_reg_idx(input string name, input logic [`REG_ADDR_W-1:0] got,
                                 input logic [`REG_ADDR_W-1:0] exp);
        if (got !== exp) begin
            $display("[ERROR] %0t %s got %0d expected %0d", $time, name, got, exp);
            stop_on_error();
        end
    endtask

    function automatic logic [`INST_W-1:0] rtype_word(input logic [5:0] funct,
        input logic [4:0] rs, input logic [4:0] rt, input logic [4:0] rd,
        input logic [4:0] shamt);
        logic [`INST_W-1:0] w;
        w = '0;
        w[`OPCODE_HI:`OPCODE_LO] = `OP_SPECIAL;
        w[`RS_HI:`RS_LO]         = rs;
        w[`RT_HI:`RT_LO]         = rt;
        w[`RD_HI:`RD_LO]         = rd;
        w[`SHAMT_HI:`SHAMT_LO]   = shamt;
        w[`FUNCT_HI:`FUNCT_LO]   = funct;
        return w;
    endfunction

    function automatic logic [`INST_W-1:0] itype_word(input logic [5:0] opcode,
        input logic [4:0] rs, input logic [4:0] rt, input logic [15:0] imm);
        return {opcode, rs, rt, imm};
    endfunction

    // ISA reference, queues one expected write per writing instruction
    task automatic apply_model(input logic [`INST_W-1:0] w);
        logic [5:0]             opcode;
        logic [5:0]             funct;
        logic [15:0]            imm;
        logic [`REG_ADDR_W-1:0] dest;
        logic [`DATA_W-1:0]     a;
        logic [`DATA_W-1:0]     b;
        logic [`DATA_W-1:0]     res;
        cpu_pkg::alu_op_e       op;
        opcode = w[31:26];
        funct  = w[5:0];
        imm    = w[15:0];
        a      = model_regs[w[25:21]];
        b      = model_regs[w[20:16]];
        dest   = w[20:16];
        op     = cpu_pkg::ALU_NOP;
        case (opcode)
            `OP_SPECIAL: begin
                dest = w[15:11];
                case (funct)
                    `FUNCT_OR:   op = cpu_pkg::ALU_OR;
                    `FUNCT_AND:  op = cpu_pkg::ALU_AND;
                    `FUNCT_XOR:  op = cpu_pkg::ALU_XOR;
                    `FUNCT_NOR:  op = cpu_pkg::ALU_NOR;
                    `FUNCT_ADDU: op = cpu_pkg::ALU_ADDU;
                    `FUNCT_SUBU: op = cpu_pkg::ALU_SUBU;
                    `FUNCT_SLT:  op = cpu_pkg::ALU_SLT;
                    `FUNCT_SLL:  op = cpu_pkg::ALU_SLL;
                    `FUNCT_SRL:  op = cpu_pkg::ALU_SRL;
                    default:     op = cpu_pkg::ALU_NOP;
                endcase
            end
            `OP_ORI: begin
                op = cpu_pkg::ALU_OR;
                b  = {16'h0, imm};
            end
            `OP_ANDI: begin
                op = cpu_pkg::ALU_AND;
                b  = {16'h0, imm};
            end
            `OP_XORI: begin
                op = cpu_pkg::ALU_XOR;
                b  = {16'h0, imm};
            end
            `OP_ADDIU: begin
                op = cpu_pkg::ALU_ADDU;
                b  = {{16{imm[15]}}, imm};
            end
            `OP_LUI: begin
                op = cpu_pkg::ALU_OR;
                a  = '0;
                b  = {imm, 16'h0};
            end
            default: op = cpu_pkg::ALU_NOP;
        endcase
        case (op)
            cpu_pkg::ALU_OR:   res = a | b;
            cpu_pkg::ALU_AND:  res = a & b;
            cpu_pkg::ALU_XOR:  res = a ^ b;
            cpu_pkg::ALU_NOR:  res = ~(a | b);
            cpu_pkg::ALU_ADDU: res = a + b;
            cpu_pkg::ALU_SUBU: res = a - b;
            cpu_pkg::ALU_SLT:  res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            cpu_pkg::ALU_SLL:  res = b << w[10:6];
            cpu_pkg::ALU_SRL:  res = b >> w[10:6];
            default:           res = '0;
        endcase
        if (op != cpu_pkg::ALU_NOP) begin
            exp_addr_q.push_back(dest);
            exp_data_q.push_back(res);
            if (dest != 0) begin
                model_regs[dest] = res;
            end
        end
    endtask

    // instruction source, answers on falling edges
    always begin
        @(negedge clk);
        if (rst && inst_req && !inst_ack) begin
            if (!zero_delay) begin
                delay = $unsigned($random(seed)) % 4;
                repeat (delay) @(negedge clk);
            end
            check_word("inst_addr", inst_addr, next_fetch_addr);
            idx = (inst_addr - `RESET_PC) >> 2;
            if (idx < prog_len) begin
                word = prog_mem[idx];
            end else begin
                word     = NOP_WORD;
                prog_len = idx + 1;
            end
            inst_data = word;
            inst_ack  = 1'b1;
            apply_model(word);
            next_fetch_addr = next_fetch_addr + `PC_STEP;
            served++;
            do @(negedge clk); while (inst_req);
            // ack may linger after the request drops
            if (!zero_delay) begin
                delay = $unsigned($random(seed)) % 2;
                repeat (delay) @(negedge clk);
            end
            inst_ack = 1'b0;
        end
    end

    // writeback monitor
    always begin
        @(negedge clk);
        if (u_dut.u_chk.fail_count != 0) begin
            $display("an assertion in cpu_chk failed");
            stop_on_error();
        end else if (rst && wb_en) begin
            if (exp_data_q.size() == 0) begin
                $display("writeback at %0t with no result expected", $time);
                stop_on_error();
            end else begin
                check_reg_idx("wb_addr", wb_addr, exp_addr_q.pop_front());
                check_word("wb_data", wb_data, exp_data_q.pop_front());
            end
        end
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= MAX_CYCLES) begin
            $display("timeout after %0d cycles, %0d writebacks still expected",
                     cycle_count, exp_data_q.size());
            stop_on_error();
        end
    end

    // appends at a rising edge, the source reads on falling edges
    task automatic emit(input logic [`INST_W-1:0] w);
        prog_mem[prog_len] = w;
        prog_len++;
    endtask

    task automatic run_until_drained();
        int end_idx;
        end_idx = prog_len;
        do @(posedge clk); while (served < end_idx || exp_data_q.size() != 0);
    endtask

    task automatic test_reset_fetch();
        @(negedge clk);
        if (!inst_req) begin
            $display("inst_req did not rise on the first cycle after reset");
            stop_on_error();
        end
        check_word("inst_addr", inst_addr, `RESET_PC);
        @(posedge clk);
        emit(itype_word(`OP_ORI, 5'd0, 5'd30, 16'h1234));
        emit(itype_word(`OP_ORI, 5'd30, 5'd31, 16'h0f00));
        emit(NOP_WORD);
        emit(itype_word(`OP_ORI, 5'd31, 5'd30, 16'h0001));
        run_until_drained();
    endtask

    task automatic test_immediates();
        emit(itype_word(`OP_ADDIU, 5'd0, 5'd1, 16'hfffb));
        emit(itype_word(`OP_ADDIU, 5'd1, 5'd2, 16'h8000));
        emit(itype_word(`OP_ADDIU, 5'd2, 5'd3, 16'h7fff));
        emit(itype_word(`OP_LUI, 5'd0, 5'd4, 16'h8001));
        emit(itype_word(`OP_LUI, 5'd1, 5'd5, 16'hffff));
        emit(itype_word(`OP_ORI, 5'd4, 5'd6, 16'hf0f0));
        emit(itype_word(`OP_ANDI, 5'd1, 5'd7, 16'h8ff0));
        emit(itype_word(`OP_XORI, 5'd1, 5'd8, 16'hffff));
        run_until_drained();
    endtask

    task automatic test_rtype();
        emit(rtype_word(`FUNCT_OR, 5'd4, 5'd6, 5'd9, 5'd0));
        emit(rtype_word(`FUNCT_AND, 5'd5, 5'd7, 5'd10, 5'd0));
        emit(rtype_word(`FUNCT_XOR, 5'd1, 5'd6, 5'd11, 5'd0));
        emit(rtype_word(`FUNCT_NOR, 5'd4, 5'd1, 5'd12, 5'd0));
        // both wrap past 2^32
        emit(rtype_word(`FUNCT_ADDU, 5'd5, 5'd4, 5'd13, 5'd0));
        emit(rtype_word(`FUNCT_SUBU, 5'd0, 5'd1, 5'd14, 5'd0));
        emit(rtype_word(`FUNCT_SLT, 5'd1, 5'd7, 5'd15, 5'd0));
        emit(rtype_word(`FUNCT_SLT, 5'd7, 5'd4, 5'd16, 5'd0));
        emit(rtype_word(`FUNCT_SLT, 5'd6, 5'd1, 5'd17, 5'd0));
        run_until_drained();
    endtask

    task automatic test_shifts();
        emit(rtype_word(`FUNCT_SLL, 5'd0, 5'd5, 5'd18, 5'd4));
        emit(rtype_word(`FUNCT_SRL, 5'd0, 5'd5, 5'd19, 5'd4));
        emit(rtype_word(`FUNCT_SRL, 5'd0, 5'd4, 5'd20, 5'd31));
        emit(rtype_word(`FUNCT_SLL, 5'd0, 5'd1, 5'd21, 5'd0));
        run_until_drained();
    endtask

    task automatic test_dep_chain();
        logic [15:0] imm;
        int          i;
        zero_delay = 1'b1;
        for (i = 0; i < 40; i++) begin
            imm = $random(seed);
            case ($unsigned($random(seed)) % 4)
                0: emit(itype_word(`OP_ADDIU, 5'd22, 5'd22, imm));
                1: emit(rtype_word(`FUNCT_XOR, 5'd22, 5'd23, 5'd23, 5'd0));
                2: emit(rtype_word(`FUNCT_ADDU, 5'd23, 5'd22, 5'd22, 5'd0));
                default: emit(rtype_word(`FUNCT_SRL, 5'd0, 5'd22, 5'd22, imm[4:0]));
            endcase
        end
        // r0 write shows on the trace but must not be forwarded
        emit(itype_word(`OP_ADDIU, 5'd22, 5'd0, 16'h0007));
        emit(rtype_word(`FUNCT_ADDU, 5'd0, 5'd22, 5'd24, 5'd0));
        emit(rtype_word(`FUNCT_OR, 5'd0, 5'd0, 5'd25, 5'd0));
        run_until_drained();
        zero_delay = 1'b0;
    endtask

    task automatic test_noop_decode();
        int i;
        for (i = 0; i < 6; i++) begin
            emit(itype_word(6'b100011, 5'd1, 5'd2, 16'h0010));
            emit(rtype_word(6'b011000, 5'd1, 5'd2, 5'd3, 5'd0));
            emit(itype_word(`OP_ADDIU, 5'd26, 5'd26, 16'h0003));
            emit(itype_word(6'b000100, 5'd26, 5'd26, 16'hffff));
            emit(rtype_word(6'b001000, 5'd26, 5'd0, 5'd27, 5'd0));
        end
        run_until_drained();
    endtask

    initial begin
        rst             = 1'b0;
        inst_ack        = 1'b0;
        inst_data       = '0;
        zero_delay      = 1'b0;
        cycle_count     = 0;
        served          = 0;
        prog_len        = 0;
        next_fetch_addr = `RESET_PC;
        for (int r = 0; r < 32; r++) begin
            model_regs[r] = '0;
        end
        repeat (2) @(posedge clk);
        @(negedge clk);
        if (inst_req || wb_en) begin
            $display("inst_req or wb_en high during reset");
            stop_on_error();
        end
        rst = 1'b1;
        test_reset_fetch();
        test_immediates();
        test_rtype();
        test_shifts();
        test_dep_chain();
        test_noop_decode();
        // writeback trails a capture by two cycles
        repeat (4) @(posedge clk);
        if (u_dut.u_chk.fail_count == 0) begin
            $display("all tests passed");
            $finish;
        end else begin
            $display("an assertion in cpu_chk failed");
            stop_on_error();
        end
    end

endmodule

//--- tb.f
+incdir+hw
hw/cpu_pkg.sv
hw/inst_fetch.sv
hw/inst_decode.sv
hw/reg_file.sv
hw/alu_execute.sv
hw/cpu_core.sv
dv/cpu_chk.sv
dv/cpu_tb.sv

//--- Bender.yml
package:
  name: mips_decode_core

sources:
  - include_dirs:
      - hw
    files:
      - hw/cpu_pkg.sv
      - hw/inst_fetch.sv
      - hw/inst_decode.sv
      - hw/reg_file.sv
      - hw/alu_execute.sv
      - hw/cpu_core.sv
  - target: test
    include_dirs:
      - hw
    files:
      - dv/cpu_chk.sv
      - dv/cpu_tb.sv
